// ==== riscv_lite.f ====
src/riscv_pkg.sv
src/instr_decoder.sv
src/register_file.sv
src/decode_stage.sv
src/execute_stage.sv
src/core_top.sv
verification/core_checker.sv
verification/core_assertions.sv
verification/core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the core testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f riscv_lite.f --top-module core_tb \
  --Mdir obj_dir -o core_sim > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/core_sim > sim.log 2>&1
cat sim.log
grep -qx "No errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== verification/core_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module core_tb;

  typedef struct packed {
    riscv_pkg::instr_t    instr;
    int                   test;
    logic                 can_stall;
    logic                 write;
    riscv_pkg::reg_addr_t rd;
    riscv_pkg::data_t     data;
  } entry_t;

  logic                 clk;
  logic                 reset;
  logic                 instr_valid;
  riscv_pkg::instr_t    instr;
  logic                 instr_ready;
  logic                 wb_valid;
  riscv_pkg::reg_addr_t wb_rd;
  riscv_pkg::data_t     wb_data;
  logic                 exp_push;
  riscv_pkg::reg_addr_t exp_rd;
  riscv_pkg::data_t     exp_data;
  int                   exp_test;
  int                   pending;
  int                   checker_errors;
  int                   checks;
  entry_t               stimulus [$];
  int                   seed;
  int                   errors;
  logic                 timed_out;

  always #5 clk = ~clk;

  core_top UUT
    ( .clk ( clk ), .reset ( reset ), .instr_valid ( instr_valid ), .instr ( instr )
    , .instr_ready ( instr_ready ), .wb_valid ( wb_valid ), .wb_rd ( wb_rd )
    , .wb_data ( wb_data )
    );

  core_checker u_checker
    ( .clk ( clk ), .reset ( reset ), .wb_valid ( wb_valid ), .wb_rd ( wb_rd )
    , .wb_data ( wb_data ), .exp_push ( exp_push ), .exp_rd ( exp_rd )
    , .exp_data ( exp_data ), .exp_test ( exp_test ), .pending ( pending )
    , .error_count ( checker_errors ), .check_count ( checks )
    );

  // Instruction encoders for the formats under test
  function automatic riscv_pkg::instr_t r_type(input logic [2:0] f3, input logic alt,
      input riscv_pkg::reg_addr_t rd, input riscv_pkg::reg_addr_t rs1,
      input riscv_pkg::reg_addr_t rs2);
    return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic riscv_pkg::instr_t i_type(input logic [2:0] f3,
      input riscv_pkg::reg_addr_t rd, input riscv_pkg::reg_addr_t rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic riscv_pkg::instr_t lui_word(input riscv_pkg::reg_addr_t rd,
      input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic riscv_pkg::instr_t sw_word(input riscv_pkg::reg_addr_t rs2,
      input riscv_pkg::reg_addr_t rs1, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  task automatic add_entry(input riscv_pkg::instr_t word, input logic can_stall,
      input logic write, input riscv_pkg::reg_addr_t rd, input riscv_pkg::data_t data);
    entry_t e;
    e.instr     = word;
    e.test      = stimulus.size() + 1;
    e.can_stall = can_stall;
    e.write     = write;
    e.rd        = rd;
    e.data      = data;
    stimulus.push_back(e);
  endtask

  // Each entry gives the word, whether the previous entry writes a source,
  // the write flag, rd and the expected value
  task automatic load_program();
    // Constants from immediates and LUI
    add_entry(i_type(3'h0, 5'd1, 5'd0, 12'd5), 1'b0, 1'b1, 5'd1, 32'h0000_0005);
    add_entry(i_type(3'h0, 5'd2, 5'd0, 12'hFFD), 1'b0, 1'b1, 5'd2, 32'hFFFF_FFFD);
    add_entry(lui_word(5'd3, 20'h12345), 1'b0, 1'b1, 5'd3, 32'h1234_5000);
    add_entry(i_type(3'h6, 5'd3, 5'd3, 12'h678), 1'b1, 1'b1, 5'd3, 32'h1234_5678);
    add_entry(lui_word(5'd4, 20'h80000), 1'b0, 1'b1, 5'd4, 32'h8000_0000);
    add_entry(i_type(3'h0, 5'd5, 5'd0, 12'd33), 1'b0, 1'b1, 5'd5, 32'h0000_0021);
    add_entry(i_type(3'h4, 5'd6, 5'd2, 12'h0F0), 1'b0, 1'b1, 5'd6, 32'hFFFF_FF0D);
    add_entry(i_type(3'h7, 5'd7, 5'd3, 12'h0FF), 1'b0, 1'b1, 5'd7, 32'h0000_0078);
    add_entry(i_type(3'h2, 5'd8, 5'd2, 12'h000), 1'b0, 1'b1, 5'd8, 32'h0000_0001);
    add_entry(i_type(3'h3, 5'd9, 5'd1, 12'hFFF), 1'b0, 1'b1, 5'd9, 32'h0000_0001);
    add_entry(i_type(3'h1, 5'd10, 5'd1, 12'h004), 1'b0, 1'b1, 5'd10, 32'h0000_0050);
    add_entry(i_type(3'h5, 5'd11, 5'd4, 12'h004), 1'b0, 1'b1, 5'd11, 32'h0800_0000);
    add_entry(i_type(3'h5, 5'd12, 5'd4, 12'h404), 1'b0, 1'b1, 5'd12, 32'hF800_0000);
    // Register-register operations
    // x5 holds a shift amount of 33
    add_entry(r_type(3'h0, 1'b0, 5'd13, 5'd1, 5'd3), 1'b0, 1'b1, 5'd13, 32'h1234_567D);
    add_entry(r_type(3'h0, 1'b1, 5'd14, 5'd1, 5'd3), 1'b0, 1'b1, 5'd14, 32'hEDCB_A98D);
    add_entry(r_type(3'h2, 1'b0, 5'd16, 5'd2, 5'd1), 1'b0, 1'b1, 5'd16, 32'h0000_0001);
    add_entry(r_type(3'h3, 1'b0, 5'd17, 5'd2, 5'd1), 1'b0, 1'b1, 5'd17, 32'h0000_0000);
    add_entry(r_type(3'h1, 1'b0, 5'd18, 5'd1, 5'd5), 1'b0, 1'b1, 5'd18, 32'h0000_000A);
    add_entry(r_type(3'h5, 1'b0, 5'd19, 5'd4, 5'd5), 1'b0, 1'b1, 5'd19, 32'h4000_0000);
    add_entry(r_type(3'h5, 1'b1, 5'd20, 5'd4, 5'd5), 1'b0, 1'b1, 5'd20, 32'hC000_0000);
    add_entry(r_type(3'h4, 1'b0, 5'd21, 5'd3, 5'd2), 1'b0, 1'b1, 5'd21, 32'hEDCB_A985);
    add_entry(r_type(3'h6, 1'b0, 5'd22, 5'd1, 5'd4), 1'b0, 1'b1, 5'd22, 32'h8000_0005);
    add_entry(r_type(3'h7, 1'b0, 5'd23, 5'd6, 5'd3), 1'b0, 1'b1, 5'd23, 32'h1234_5608);
    // Dependent chains
    add_entry(i_type(3'h0, 5'd24, 5'd0, 12'd1), 1'b0, 1'b1, 5'd24, 32'h0000_0001);
    add_entry(i_type(3'h0, 5'd24, 5'd24, 12'd2), 1'b1, 1'b1, 5'd24, 32'h0000_0003);
    add_entry(i_type(3'h0, 5'd24, 5'd24, 12'd4), 1'b1, 1'b1, 5'd24, 32'h0000_0007);
    add_entry(i_type(3'h0, 5'd26, 5'd1, 12'd10), 1'b0, 1'b1, 5'd26, 32'h0000_000F);
    add_entry(i_type(3'h0, 5'd27, 5'd2, 12'd1), 1'b0, 1'b1, 5'd27, 32'hFFFF_FFFE);
    add_entry(r_type(3'h0, 1'b1, 5'd28, 5'd26, 5'd27), 1'b1, 1'b1, 5'd28, 32'h0000_0011);
    // x0 as destination and then as source
    add_entry(i_type(3'h0, 5'd0, 5'd1, 12'd100), 1'b0, 1'b0, 5'd0, 32'h0);
    add_entry(r_type(3'h0, 1'b0, 5'd29, 5'd0, 5'd0), 1'b0, 1'b1, 5'd29, 32'h0000_0000);
    // Stores are consumed without a write
    add_entry(sw_word(5'd1, 5'd2, 12'd0), 1'b0, 1'b0, 5'd0, 32'h0);
    add_entry(i_type(3'h0, 5'd30, 5'd1, 12'd1), 1'b0, 1'b1, 5'd30, 32'h0000_0006);
    add_entry(sw_word(5'd30, 5'd0, 12'd4), 1'b0, 1'b0, 5'd0, 32'h0);
    add_entry(r_type(3'h0, 1'b0, 5'd31, 5'd30, 5'd1), 1'b0, 1'b1, 5'd31, 32'h0000_000B);
  endtask

  // Offers one entry and waits for its transfer with ready sampled mid-cycle
  task automatic send_entry(input entry_t e);
    int   waits;
    logic got;
    waits       = 0;
    got         = 1'b0;
    instr_valid = 1'b1;
    instr       = e.instr;
    while (!got && waits < 20) begin
      @(negedge clk);
      if (instr_ready) begin
        got = 1'b1;
      end else begin
        waits++;
        if (!e.can_stall) begin
          $display("Test %0d: instr_ready dropped although no source was pending", e.test);
          errors++;
        end
      end
      @(posedge clk);
      #1;
      exp_push = 1'b0;
    end
    instr_valid = 1'b0;
    if (!got) begin
      $display("Timeout: test %0d was not accepted within 20 cycles", e.test);
      errors++;
      timed_out = 1'b1;
    end else if (e.write) begin
      exp_push = 1'b1;
      exp_rd   = e.rd;
      exp_data = e.data;
      exp_test = e.test;
    end else begin
      $display("Test %0d ok: accepted with no retire", e.test);
    end
  endtask

  initial begin
    int gap;
    int drain;
    int total;
    clk         = 1'b0;
    reset       = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    exp_push    = 1'b0;
    exp_rd      = '0;
    exp_data    = '0;
    exp_test    = 0;
    errors      = 0;
    timed_out   = 1'b0;
    seed        = 32'hd763ecf2;
    load_program();
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    for (int i = 0; i < stimulus.size() && !timed_out; i++) begin
      // Dependent entries go back to back so the interlock is exercised
      gap = 0;
      if (!stimulus[i].can_stall) begin
        gap = $unsigned($random(seed)) % 3;
      end
      repeat (gap) begin
        @(posedge clk);
        #1;
        exp_push = 1'b0;
      end
      send_entry(stimulus[i]);
    end
    drain = 0;
    while ((pending != 0 || exp_push) && drain < 50) begin
      @(posedge clk);
      #1;
      exp_push = 1'b0;
      drain++;
    end
    if (pending != 0) begin
      $display("Timeout: %0d expected retires never arrived", pending);
      errors++;
    end
    total = errors + checker_errors + UUT.u_assertions.failures;
    $display("Summary: %0d tests, %0d retires checked, %0d errors",
             stimulus.size(), checks, total);
    if (total == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/core_assertions.sv ====
`timescale 1ns/100ps
`default_nettype none

module core_assertions
  ( input logic                 clk
  , input logic                 reset
  , input logic                 instr_valid
  , input logic                 instr_ready
  , input riscv_pkg::instr_t    instr
  , input logic                 wb_valid
  , input riscv_pkg::reg_addr_t wb_rd
  );

  logic writes;
  // Number of failed assertions
  int   failures = 0;

  // Supported opcode with a nonzero destination
  assign writes = ((instr[6:0] == riscv_pkg::OPC_OP) || (instr[6:0] == riscv_pkg::OPC_OP_IMM)
                   || (instr[6:0] == riscv_pkg::OPC_LUI)) && (instr[11:7] != 5'd0);

  retire_not_x0: assert property (@(posedge clk) disable iff (reset)
    wb_valid |-> (wb_rd != 5'd0))
    else begin
      failures++;
      $error("Retire reported for register x0");
    end

  ready_after_reset: assert property (@(posedge clk)
    $fell(reset) |-> instr_ready)
    else begin
      failures++;
      $error("instr_ready low in the first cycle after reset");
    end

  write_retires: assert property (@(posedge clk) disable iff (reset)
    (instr_valid && instr_ready && writes) |-> ##2 wb_valid)
    else begin
      failures++;
      $error("Writing instruction did not retire two cycles after transfer");
    end

endmodule

bind core_top core_assertions u_assertions
  ( .clk         ( clk         )
  , .reset       ( reset       )
  , .instr_valid ( instr_valid )
  , .instr_ready ( instr_ready )
  , .instr       ( instr       )
  , .wb_valid    ( wb_valid    )
  , .wb_rd       ( wb_rd       )
  );

`default_nettype wire

// ==== verification/core_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module core_checker
  ( input  logic                 clk
  , input  logic                 reset
  , input  logic                 wb_valid
  , input  riscv_pkg::reg_addr_t wb_rd
  , input  riscv_pkg::data_t     wb_data
  , input  logic                 exp_push
  , input  riscv_pkg::reg_addr_t exp_rd
  , input  riscv_pkg::data_t     exp_data
  , input  int                   exp_test
  , output int                   pending
  , output int                   error_count
  , output int                   check_count
  );

  typedef struct packed {
    int                   test;
    riscv_pkg::reg_addr_t rd;
    riscv_pkg::data_t     data;
  } expect_t;

  expect_t expect_q [$];
  expect_t head;
  logic    ok;

  always @(posedge clk) begin
    if (reset) begin
      expect_q.delete();
      error_count = 0;
      check_count = 0;
    end else begin
      // Push before pop, an expectation always leads its retire by one edge
      if (exp_push) begin
        expect_q.push_back({exp_test, exp_rd, exp_data});
      end
      if (wb_valid) begin
        if (expect_q.size() == 0) begin
          $display("Retire of x%0d arrived while no result was expected", wb_rd);
          error_count++;
        end else begin
          head = expect_q.pop_front();
          ok = 1'b1;
          check_count++;
          if (wb_rd != head.rd) begin
            $display("Fail: test %0d wb_rd got %h expected %h", head.test, wb_rd, head.rd);
            ok = 1'b0;
          end
          if (wb_data != head.data) begin
            $display("Fail: test %0d wb_data got %h expected %h",
                     head.test, wb_data, head.data);
            ok = 1'b0;
          end
          if (ok) begin
            $display("Test %0d ok: x%0d = %h", head.test, wb_rd, wb_data);
          end else begin
            error_count++;
          end
        end
      end
    end
    pending = expect_q.size();
  end

endmodule

`default_nettype wire

// ==== src/core_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module core_top
  ( input  logic                 clk
  , input  logic                 reset
  , input  logic                 instr_valid
  , input  riscv_pkg::instr_t    instr
  , output logic                 instr_ready
  , output logic                 wb_valid
  , output riscv_pkg::reg_addr_t wb_rd
  , output riscv_pkg::data_t     wb_data
  );

  riscv_pkg::id_to_ex_t id_to_ex;
  riscv_pkg::ex_to_wb_t ex_to_wb;

  decode_stage u_decode
    ( .clk         ( clk         )
    , .reset       ( reset       )
    , .instr_valid ( instr_valid )
    , .instr       ( instr       )
    , .instr_ready ( instr_ready )
    , .wb          ( ex_to_wb    )
    , .id_to_ex    ( id_to_ex    )
    );

  execute_stage u_execute
    ( .clk      ( clk      )
    , .reset    ( reset    )
    , .id_to_ex ( id_to_ex )
    , .ex_to_wb ( ex_to_wb )
    );

  // Retire mirrors the register file write port
  assign wb_valid = ex_to_wb.valid && ex_to_wb.reg_write;
  assign wb_rd    = ex_to_wb.rd;
  assign wb_data  = ex_to_wb.result;

endmodule

`default_nettype wire

// ==== src/execute_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module execute_stage
  ( input  logic                 clk
  , input  logic                 reset
  , input  riscv_pkg::id_to_ex_t id_to_ex
  , output riscv_pkg::ex_to_wb_t ex_to_wb
  );

  riscv_pkg::data_t alu_result;
  riscv_pkg::data_t op_a;
  riscv_pkg::data_t op_b;
  logic [4:0]       shamt;

  assign op_a  = id_to_ex.operand_a;
  assign op_b  = id_to_ex.operand_b;
  // Only the low 5 bits count for shifts
  assign shamt = op_b[4:0];

  always_comb begin
    case (id_to_ex.alu_ctrl)
      riscv_pkg::ALU_ADD: begin
        alu_result = op_a + op_b;
      end
      riscv_pkg::ALU_SUB: begin
        alu_result = op_a - op_b;
      end
      riscv_pkg::ALU_SLL: begin
        alu_result = op_a << shamt;
      end
      riscv_pkg::ALU_SLT: begin
        alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
      end
      riscv_pkg::ALU_SLTU: begin
        alu_result = {31'b0, op_a < op_b};
      end
      riscv_pkg::ALU_XOR: begin
        alu_result = op_a ^ op_b;
      end
      riscv_pkg::ALU_SRL: begin
        alu_result = op_a >> shamt;
      end
      riscv_pkg::ALU_SRA: begin
        alu_result = $unsigned($signed(op_a) >>> shamt);
      end
      riscv_pkg::ALU_OR: begin
        alu_result = op_a | op_b;
      end
      riscv_pkg::ALU_AND: begin
        alu_result = op_a & op_b;
      end
      riscv_pkg::ALU_PASS_B: begin
        alu_result = op_b;
      end
      default: begin
        alu_result = op_a + op_b;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_to_wb.valid     <= 1'b0;
      ex_to_wb.reg_write <= 1'b0;
    end else begin
      ex_to_wb.valid     <= id_to_ex.valid;
      ex_to_wb.reg_write <= id_to_ex.valid && id_to_ex.reg_write;
    end
  end

  // Payload follows every cycle, qualified by valid
  always_ff @(posedge clk) begin
    ex_to_wb.rd     <= id_to_ex.rd;
    ex_to_wb.result <= alu_result;
  end

endmodule

`default_nettype wire

// ==== src/decode_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module decode_stage
  ( input  logic                  clk
  , input  logic                  reset
  , input  logic                  instr_valid
  , input  riscv_pkg::instr_t     instr
  , output logic                  instr_ready
  , input  riscv_pkg::ex_to_wb_t  wb
  , output riscv_pkg::id_to_ex_t  id_to_ex
  );

  riscv_pkg::reg_addr_t rd;
  riscv_pkg::reg_addr_t rs1;
  riscv_pkg::reg_addr_t rs2;
  logic                 uses_rs1;
  logic                 uses_rs2;
  logic                 use_imm;
  riscv_pkg::data_t     imm_ext;
  riscv_pkg::alu_ctrl_t alu_ctrl;
  logic                 reg_write;

  riscv_pkg::data_t rd1;
  riscv_pkg::data_t rd2;
  riscv_pkg::data_t operand_a;
  riscv_pkg::data_t operand_b;

  logic ex_writes;
  logic hazard_rs1;
  logic hazard_rs2;
  logic transfer;

  instr_decoder u_instr_decoder
    ( .instr     ( instr     )
    , .rd        ( rd        )
    , .rs1       ( rs1       )
    , .rs2       ( rs2       )
    , .uses_rs1  ( uses_rs1  )
    , .uses_rs2  ( uses_rs2  )
    , .use_imm   ( use_imm   )
    , .imm_ext   ( imm_ext   )
    , .alu_ctrl  ( alu_ctrl  )
    , .reg_write ( reg_write )
    );

  register_file u_register_file
    ( .clk   ( clk                        )
    , .reset ( reset                      )
    , .rs1   ( rs1                        )
    , .rs2   ( rs2                        )
    , .rd1   ( rd1                        )
    , .rd2   ( rd2                        )
    , .we    ( wb.valid && wb.reg_write   )
    , .wa    ( wb.rd                      )
    , .wd    ( wb.result                  )
    );

  // Result still sitting in execute is not yet visible to the register file
  assign ex_writes  = id_to_ex.valid && id_to_ex.reg_write && (id_to_ex.rd != '0);
  assign hazard_rs1 = uses_rs1 && (rs1 == id_to_ex.rd);
  assign hazard_rs2 = uses_rs2 && (rs2 == id_to_ex.rd);

  // One stall cycle is enough, writeback covers the rest through write-through
  assign instr_ready = !(ex_writes && (hazard_rs1 || hazard_rs2));
  assign transfer    = instr_valid && instr_ready;

  // LUI has no rs1 and adds its immediate to zero
  assign operand_a = uses_rs1 ? rd1 : '0;
  assign operand_b = use_imm ? imm_ext : rd2;

  always_ff @(posedge clk) begin
    if (reset) begin
      id_to_ex.valid     <= 1'b0;
      id_to_ex.reg_write <= 1'b0;
    end else begin
      // A stall or an idle input leaves a bubble
      id_to_ex.valid     <= transfer;
      id_to_ex.reg_write <= transfer && reg_write;
    end
  end

  always_ff @(posedge clk) begin
    if (transfer) begin
      id_to_ex.rd        <= rd;
      id_to_ex.alu_ctrl  <= alu_ctrl;
      id_to_ex.operand_a <= operand_a;
      id_to_ex.operand_b <= operand_b;
    end
  end

endmodule

`default_nettype wire

// ==== src/register_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module register_file
  ( input  logic                 clk
  , input  logic                 reset
  , input  riscv_pkg::reg_addr_t rs1
  , input  riscv_pkg::reg_addr_t rs2
  , output riscv_pkg::data_t     rd1
  , output riscv_pkg::data_t     rd2
  , input  logic                 we
  , input  riscv_pkg::reg_addr_t wa
  , input  riscv_pkg::data_t     wd
  );

  riscv_pkg::data_t regs [32];
  logic             write_hit;

  // x0 stays hardwired to zero
  assign write_hit = we && (wa != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (write_hit) begin
      regs[wa] <= wd;
    end
  end

  // Write-through, so a reader in the writeback cycle sees the new value
  assign rd1 = (write_hit && (wa == rs1)) ? wd : regs[rs1];
  assign rd2 = (write_hit && (wa == rs2)) ? wd : regs[rs2];

endmodule

`default_nettype wire

// ==== src/instr_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module instr_decoder
  ( input  riscv_pkg::instr_t    instr
  , output riscv_pkg::reg_addr_t rd
  , output riscv_pkg::reg_addr_t rs1
  , output riscv_pkg::reg_addr_t rs2
  , output logic                 uses_rs1
  , output logic                 uses_rs2
  , output logic                 use_imm
  , output riscv_pkg::data_t     imm_ext
  , output riscv_pkg::alu_ctrl_t alu_ctrl
  , output logic                 reg_write
  );

  riscv_pkg::opcode_t opcode;
  riscv_pkg::funct3_t funct3;
  logic               alt_op;
  logic               is_op;
  logic               is_op_imm;
  logic               is_lui;
  logic               rd_nonzero;

  assign opcode = instr[6:0];
  assign rd     = instr[11:7];
  assign funct3 = instr[14:12];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  // funct7 bit 30 picks SUB and SRA
  assign alt_op = instr[30];

  assign is_op      = (opcode == riscv_pkg::OPC_OP);
  assign is_op_imm  = (opcode == riscv_pkg::OPC_OP_IMM);
  assign is_lui     = (opcode == riscv_pkg::OPC_LUI);
  assign rd_nonzero = (rd != '0);

  // I-type sign extended, U-type in the upper 20 bits
  always_comb begin
    if (is_lui) begin
      imm_ext = {instr[31:12], 12'b0};
    end else begin
      imm_ext = {{20{instr[31]}}, instr[31:20]};
    end
  end

  always_comb begin
    alu_ctrl = riscv_pkg::ALU_ADD;
    if (is_lui) begin
      alu_ctrl = riscv_pkg::ALU_PASS_B;
    end else if (is_op || is_op_imm) begin
      case (funct3)
        riscv_pkg::F3_ADD_SUB: begin
          // No subtract-immediate exists, so bit 30 only matters for OP
          if (is_op && alt_op) begin
            alu_ctrl = riscv_pkg::ALU_SUB;
          end else begin
            alu_ctrl = riscv_pkg::ALU_ADD;
          end
        end
        riscv_pkg::F3_SLL:  alu_ctrl = riscv_pkg::ALU_SLL;
        riscv_pkg::F3_SLT:  alu_ctrl = riscv_pkg::ALU_SLT;
        riscv_pkg::F3_SLTU: alu_ctrl = riscv_pkg::ALU_SLTU;
        riscv_pkg::F3_XOR:  alu_ctrl = riscv_pkg::ALU_XOR;
        riscv_pkg::F3_SRL_SRA: begin
          if (alt_op) begin
            alu_ctrl = riscv_pkg::ALU_SRA;
          end else begin
            alu_ctrl = riscv_pkg::ALU_SRL;
          end
        end
        riscv_pkg::F3_OR:   alu_ctrl = riscv_pkg::ALU_OR;
        riscv_pkg::F3_AND:  alu_ctrl = riscv_pkg::ALU_AND;
        default:            alu_ctrl = riscv_pkg::ALU_ADD;
      endcase
    end
  end

  // Unsupported opcodes and writes to x0 become no-ops with no sources
  assign reg_write = (is_op || is_op_imm || is_lui) && rd_nonzero;
  assign uses_rs1  = (is_op || is_op_imm) && rd_nonzero;
  assign uses_rs2  = is_op && rd_nonzero;
  assign use_imm   = is_op_imm || is_lui;

endmodule

`default_nettype wire

// ==== src/riscv_pkg.sv ====
`default_nettype none

package riscv_pkg;

  // Widths fixed by RV32I
  typedef logic [31:0] data_t;
  typedef logic [31:0] instr_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [2:0]  funct3_t;
  typedef logic [3:0]  alu_ctrl_t;

  // Major opcodes handled by the core
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_LUI    = 7'b0110111;

  // funct3 field of the integer ALU group
  localparam funct3_t F3_ADD_SUB = 3'b000;
  localparam funct3_t F3_SLL     = 3'b001;
  localparam funct3_t F3_SLT     = 3'b010;
  localparam funct3_t F3_SLTU    = 3'b011;
  localparam funct3_t F3_XOR     = 3'b100;
  localparam funct3_t F3_SRL_SRA = 3'b101;
  localparam funct3_t F3_OR      = 3'b110;
  localparam funct3_t F3_AND     = 3'b111;

  // ALU operation codes
  localparam alu_ctrl_t ALU_ADD    = 4'd0;
  localparam alu_ctrl_t ALU_SUB    = 4'd1;
  localparam alu_ctrl_t ALU_SLL    = 4'd2;
  localparam alu_ctrl_t ALU_SLT    = 4'd3;
  localparam alu_ctrl_t ALU_SLTU   = 4'd4;
  localparam alu_ctrl_t ALU_XOR    = 4'd5;
  localparam alu_ctrl_t ALU_SRL    = 4'd6;
  localparam alu_ctrl_t ALU_SRA    = 4'd7;
  localparam alu_ctrl_t ALU_OR     = 4'd8;
  localparam alu_ctrl_t ALU_AND    = 4'd9;
  // Forwards operand_b unchanged, LUI only
  localparam alu_ctrl_t ALU_PASS_B = 4'd10;

  typedef struct packed {
    logic      valid;
    logic      reg_write;
    reg_addr_t rd;
    alu_ctrl_t alu_ctrl;
    data_t     operand_a;
    data_t     operand_b;
  } id_to_ex_t;

  typedef struct packed {
    logic      valid;
    logic      reg_write;
    reg_addr_t rd;
    data_t     result;
  } ex_to_wb_t;

endpackage

`default_nettype wire
